//--- rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam logic [31:0] reset_pc    = 32'h8000_0000;
    localparam int          dmem_words  = 256;
    localparam logic [31:0] ebreak_inst = 32'h0010_0073;

    // Major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    // ALU operations
    localparam logic [3:0] alu_add    = 4'd0;
    localparam logic [3:0] alu_sub    = 4'd1;
    localparam logic [3:0] alu_sll    = 4'd2;
    localparam logic [3:0] alu_slt    = 4'd3;
    localparam logic [3:0] alu_sltu   = 4'd4;
    localparam logic [3:0] alu_xor    = 4'd5;
    localparam logic [3:0] alu_srl    = 4'd6;
    localparam logic [3:0] alu_sra    = 4'd7;
    localparam logic [3:0] alu_or     = 4'd8;
    localparam logic [3:0] alu_and    = 4'd9;
    localparam logic [3:0] alu_pass_b = 4'd10; // LUI

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // Same 32 bits, one view per encoding format
    typedef union packed {
        r_fmt_t r_view;
        i_fmt_t i_view;
        s_fmt_t s_view;
        b_fmt_t b_view;
        u_fmt_t u_view;
        j_fmt_t j_view;
    } inst_u;

endpackage

`default_nettype wire

//--- inst_decoder.sv
`default_nettype none

module inst_decoder (
    input  rv_pkg::inst_u inst,
    output logic [4:0]    rs1,
    output logic [4:0]    rs2,
    output logic [4:0]    rd,
    output logic [31:0]   imm,
    output logic [2:0]    funct3,
    output logic [3:0]    alu_op,
    output logic          src_a_pc,
    output logic          src_b_imm,
    output logic          reg_wen,
    output logic          mem_wen,
    output logic          mem_ren,
    output logic          is_jump,
    output logic          is_branch,
    output logic          is_ebreak
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic       alt;

    function automatic logic [3:0] alu_from_funct(input logic [2:0] f3, input logic sub_sra);
        logic [3:0] op;
        case (f3)
            3'b000:  op = sub_sra ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = sub_sra ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    assign opcode    = inst.r_view.opcode;
    assign rs1       = inst.r_view.rs1;
    assign rs2       = inst.r_view.rs2;
    assign rd        = inst.r_view.rd;
    assign funct3    = inst.r_view.funct3;
    assign alt       = inst.r_view.funct7[5];
    assign is_ebreak = (inst == ebreak_inst);

    always_comb begin
        imm       = '0;
        alu_op    = alu_add;
        src_a_pc  = 1'b0;
        src_b_imm = 1'b0;
        reg_wen   = 1'b0;
        mem_wen   = 1'b0;
        mem_ren   = 1'b0;
        is_jump   = 1'b0;
        is_branch = 1'b0;
        case (opcode)
            op_lui: begin
                imm       = {inst.u_view.imm_31_12, 12'h000};
                alu_op    = alu_pass_b;
                src_b_imm = 1'b1;
                reg_wen   = 1'b1;
            end
            op_auipc: begin
                imm       = {inst.u_view.imm_31_12, 12'h000};
                src_a_pc  = 1'b1;
                src_b_imm = 1'b1;
                reg_wen   = 1'b1;
            end
            op_jal: begin
                imm = {{11{inst.j_view.imm_20}}, inst.j_view.imm_20, inst.j_view.imm_19_12,
                       inst.j_view.imm_11, inst.j_view.imm_10_1, 1'b0};
                src_a_pc  = 1'b1; // Target is pc + imm
                src_b_imm = 1'b1;
                reg_wen   = 1'b1;
                is_jump   = 1'b1;
            end
            op_jalr: begin
                imm       = {{20{inst.i_view.imm_11_0[11]}}, inst.i_view.imm_11_0};
                src_b_imm = 1'b1;
                reg_wen   = 1'b1;
                is_jump   = 1'b1;
            end
            op_branch: begin
                imm = {{19{inst.b_view.imm_12}}, inst.b_view.imm_12, inst.b_view.imm_11,
                       inst.b_view.imm_10_5, inst.b_view.imm_4_1, 1'b0};
                case (funct3[2:1])
                    2'b10:   alu_op = alu_slt;
                    2'b11:   alu_op = alu_sltu;
                    default: alu_op = alu_sub; // BEQ/BNE
                endcase
                is_branch = 1'b1;
            end
            op_load: begin
                imm       = {{20{inst.i_view.imm_11_0[11]}}, inst.i_view.imm_11_0};
                src_b_imm = 1'b1;
                reg_wen   = 1'b1;
                mem_ren   = 1'b1;
            end
            op_store: begin
                imm       = {{20{inst.s_view.imm_11_5[6]}}, inst.s_view.imm_11_5,
                             inst.s_view.imm_4_0};
                src_b_imm = 1'b1;
                mem_wen   = 1'b1;
            end
            op_imm: begin
                imm       = {{20{inst.i_view.imm_11_0[11]}}, inst.i_view.imm_11_0};
                alu_op    = alu_from_funct(funct3, (funct3 == 3'b101) && alt); // Only SRAI
                src_b_imm = 1'b1;
                reg_wen   = 1'b1;
            end
            op_reg: begin
                alu_op  = alu_from_funct(funct3, alt);
                reg_wen = 1'b1;
            end
            default: ; // No-op
        endcase
    end

endmodule

`default_nettype wire

//--- reg_file.sv
`default_nettype none

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic [31:0] rd_value,
    input  logic        wen,
    output logic [31:0] rs1_value,
    output logic [31:0] rs2_value,
    output logic [31:0] a0_value
);

    logic [31:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != 5'd0) begin
            regs[rd] <= rd_value;
        end
    end

    assign rs1_value = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rs2_value = (rs2 == 5'd0) ? 32'd0 : regs[rs2];
    assign a0_value  = regs[10];

    // A register written at one edge reads back through port 1 at the next
    write_readback: assert property (@(posedge clk) disable iff (!rst_n)
        wen && rd != 5'd0 |=> rs1 != $past(rd) || rs1_value == $past(rd_value))
        else $error("register write did not read back");

endmodule

`default_nettype wire

//--- alu.sv
`default_nettype none

module alu (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [3:0]  alu_op,
    input  logic [2:0]  funct3,
    input  logic        is_branch,
    output logic [31:0] result,
    output logic        branch_taken
);
    import rv_pkg::*;

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = (a == b);
    assign lt  = ($signed(a) < $signed(b));
    assign ltu = (a < b);

    always_comb begin
        case (alu_op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_sll:    result = a << b[4:0];
            alu_slt:    result = {31'd0, lt};
            alu_sltu:   result = {31'd0, ltu};
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> b[4:0];
            alu_sra:    result = $signed(a) >>> b[4:0];
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_pass_b: result = b;
            default:    result = '0;
        endcase
    end

    // Branch condition straight from funct3
    always_comb begin
        branch_taken = 1'b0;
        if (is_branch) begin
            case (funct3)
                3'b000:  branch_taken = eq;
                3'b001:  branch_taken = !eq;
                3'b100:  branch_taken = lt;
                3'b101:  branch_taken = !lt;
                3'b110:  branch_taken = ltu;
                3'b111:  branch_taken = !ltu;
                default: branch_taken = 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- data_mem.sv
`default_nettype none

module data_mem (
    input  logic        clk,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic [2:0]  funct3,
    input  logic        wen,
    output logic [31:0] rdata
);
    import rv_pkg::*;

    logic [31:0] mem [dmem_words];
    logic [$clog2(dmem_words)-1:0] word_idx;
    logic [3:0]  be;
    logic [31:0] lane_data;
    logic [31:0] shifted;

    assign word_idx = addr[$clog2(dmem_words)+1:2]; // Wraps at memory size

    always_comb begin
        case (funct3[1:0])
            2'b00: begin
                be        = 4'b0001 << addr[1:0];
                lane_data = {4{wdata[7:0]}};
            end
            2'b01: begin
                be        = addr[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{wdata[15:0]}};
            end
            default: begin
                be        = 4'b1111;
                lane_data = wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (wen) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) mem[word_idx][8*i +: 8] <= lane_data[8*i +: 8];
            end
        end
    end

    assign shifted = mem[word_idx] >> {addr[1:0], 3'b000};

    always_comb begin
        case (funct3)
            3'b000:  rdata = {{24{shifted[7]}}, shifted[7:0]};
            3'b001:  rdata = {{16{shifted[15]}}, shifted[15:0]};
            3'b100:  rdata = {24'd0, shifted[7:0]};
            3'b101:  rdata = {16'd0, shifted[15:0]};
            default: rdata = mem[word_idx];
        endcase
    end

    store_aligned: assert property (@(posedge clk)
        wen |-> funct3[1:0] == 2'b00 || (funct3[1:0] == 2'b01 && !addr[0]) || addr[1:0] == 2'b00)
        else $error("misaligned store to %h", addr);

endmodule

`default_nettype wire

//--- rv_core.sv
`default_nettype none

module rv_core (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] inst,
    output logic [31:0] pc,
    output logic        halted,
    output logic [31:0] a0
);
    import rv_pkg::*;

    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    logic [2:0]  funct3;
    logic [3:0]  alu_op;
    logic        src_a_pc;
    logic        src_b_imm;
    logic        reg_wen;
    logic        mem_wen;
    logic        mem_ren;
    logic        is_jump;
    logic        is_branch;
    logic        is_ebreak;

    logic [31:0] rs1_value;
    logic [31:0] rs2_value;
    logic [31:0] a0_value;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] result;
    logic        branch_taken;
    logic [31:0] load_data;
    logic [31:0] rd_value;
    logic [31:0] pc_plus4;
    logic [31:0] next_pc;
    logic        stop;

    assign stop     = halted | is_ebreak; // EBREAK retires nothing
    assign pc_plus4 = pc + 32'd4;
    assign op_a     = src_a_pc ? pc : rs1_value;
    assign op_b     = src_b_imm ? imm : rs2_value;
    assign a0       = a0_value;

    always_comb begin
        if (stop) begin
            next_pc = pc;
        end else if (is_jump) begin
            next_pc = {result[31:1], 1'b0};
        end else if (branch_taken) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_comb begin
        if (is_jump) begin
            rd_value = pc_plus4; // Link
        end else if (mem_ren) begin
            rd_value = load_data;
        end else begin
            rd_value = result;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc     <= reset_pc;
            halted <= 1'b0;
        end else begin
            pc <= next_pc;
            if (is_ebreak) halted <= 1'b1; // Sticky until reset
        end
    end

    inst_decoder u_inst_decoder (
        .inst      (inst),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm       (imm),
        .funct3    (funct3),
        .alu_op    (alu_op),
        .src_a_pc  (src_a_pc),
        .src_b_imm (src_b_imm),
        .reg_wen   (reg_wen),
        .mem_wen   (mem_wen),
        .mem_ren   (mem_ren),
        .is_jump   (is_jump),
        .is_branch (is_branch),
        .is_ebreak (is_ebreak)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .rd_value  (rd_value),
        .wen       (reg_wen & ~stop),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .a0_value  (a0_value)
    );

    alu u_alu (
        .a            (op_a),
        .b            (op_b),
        .alu_op       (alu_op),
        .funct3       (funct3),
        .is_branch    (is_branch),
        .result       (result),
        .branch_taken (branch_taken)
    );

    // No stores while the core sits in reset
    data_mem u_data_mem (
        .clk    (clk),
        .addr   (result),
        .wdata  (rs2_value),
        .funct3 (funct3),
        .wen    (mem_wen & ~stop & rst_n),
        .rdata  (load_data)
    );

    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("pc %h not word aligned", pc);

    // Every supported opcode raises at least one of these
    known_opcode: assert property (@(posedge clk) disable iff (!rst_n)
        !halted |-> reg_wen || mem_wen || is_branch || is_ebreak)
        else $error("unsupported instruction %h at pc %h", inst, pc);

endmodule

`default_nettype wire

//--- tb_rv_core.sv
`default_nettype none

module tb_rv_core;
    import rv_pkg::*;

    // Each test needs under 8 reset, 200 run and 10 hold cycles
    localparam int max_cycles = 5000;

    logic        clk;
    logic        rst_n;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        halted;
    logic [31:0] a0;

    logic [31:0] imem [0:63];
    int          prog_len;
    int          cycles;
    int          checks_passed;
    int          checks_failed;

    rv_core u_rv_core (
        .clk    (clk),
        .rst_n  (rst_n),
        .inst   (inst),
        .pc     (pc),
        .halted (halted),
        .a0     (a0)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("Timeout: the core did not finish within %0d cycles", max_cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] fetch(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - reset_pc) >> 2;
        if (idx < 32'd64) begin
            return imem[idx[5:0]];
        end else begin
            return ebreak_inst; // Off the end of the program
        end
    endfunction

    // Instruction memory answers 2 units after each edge
    always @(posedge clk) begin
        #2;
        inst = fetch(pc);
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        inst_u w;
        w.r_view.funct7 = f7;
        w.r_view.rs2    = rs2;
        w.r_view.rs1    = rs1;
        w.r_view.funct3 = f3;
        w.r_view.rd     = rd;
        w.r_view.opcode = op_reg;
        return w;
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opcode);
        inst_u w;
        w.i_view.imm_11_0 = imm;
        w.i_view.rs1      = rs1;
        w.i_view.funct3   = f3;
        w.i_view.rd       = rd;
        w.i_view.opcode   = opcode;
        return w;
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        inst_u w;
        w.s_view.imm_11_5 = imm[11:5];
        w.s_view.rs2      = rs2;
        w.s_view.rs1      = rs1;
        w.s_view.funct3   = f3;
        w.s_view.imm_4_0  = imm[4:0];
        w.s_view.opcode   = op_store;
        return w;
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        inst_u w;
        w.b_view.imm_12   = imm[12];
        w.b_view.imm_10_5 = imm[10:5];
        w.b_view.rs2      = rs2;
        w.b_view.rs1      = rs1;
        w.b_view.funct3   = f3;
        w.b_view.imm_4_1  = imm[4:1];
        w.b_view.imm_11   = imm[11];
        w.b_view.opcode   = op_branch;
        return w;
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opcode);
        inst_u w;
        w.u_view.imm_31_12 = imm;
        w.u_view.rd        = rd;
        w.u_view.opcode    = opcode;
        return w;
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        inst_u w;
        w.j_view.imm_20    = imm[20];
        w.j_view.imm_10_1  = imm[10:1];
        w.j_view.imm_11    = imm[11];
        w.j_view.imm_19_12 = imm[19:12];
        w.j_view.rd        = rd;
        w.j_view.opcode    = op_jal;
        return w;
    endfunction

    task automatic new_program();
        prog_len = 0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = i_type(12'(i), 5'd0, 3'b000, 5'd0, op_imm); // addi x0, x0, index
        end
    endtask

    task automatic emit(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    // LUI and ADDI with the upper part rounded up when bit 11 is set
    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        emit(u_type(upper[31:12], rd, op_lui));
        emit(i_type(value[11:0], rd, 3'b000, rd, op_imm));
    endtask

    task automatic reset_dut();
        @(posedge clk);
        #2;
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            checks_failed++;
        end else begin
            checks_passed++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %b, actual %b", name, expected, actual);
            checks_failed++;
        end else begin
            checks_passed++;
        end
    endtask

    task automatic run_program(input string name);
        reset_dut();
        check_flag({name, " halted after reset"}, 1'b0, halted);
        check_word({name, " pc after reset"}, reset_pc, pc);
        while (!halted) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic report_test(input string name, input int fails_before);
        if (checks_failed == fails_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed", name);
        end
    endtask

    task automatic arith_chain();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] acc;
        logic [4:0]  sh;
        logic [11:0] imm;
        logic [31:0] res [11];
        int          fails_before;
        fails_before = checks_failed;
        a   = $urandom();
        b   = $urandom();
        sh  = 5'($urandom());
        imm = 12'($urandom());
        new_program();
        load_const(5'd5, a);
        load_const(5'd6, b);
        emit(i_type({7'd0, sh}, 5'd0, 3'b000, 5'd7, op_imm));
        emit(r_type(7'h00, 5'd6, 5'd5, 3'b000, 5'd11)); // add
        emit(r_type(7'h20, 5'd6, 5'd5, 3'b000, 5'd12)); // sub
        emit(r_type(7'h00, 5'd6, 5'd5, 3'b100, 5'd13));
        emit(r_type(7'h00, 5'd6, 5'd5, 3'b110, 5'd14));
        emit(r_type(7'h00, 5'd6, 5'd5, 3'b111, 5'd15));
        emit(r_type(7'h00, 5'd6, 5'd5, 3'b010, 5'd16)); // slt
        emit(r_type(7'h00, 5'd6, 5'd5, 3'b011, 5'd17)); // sltu
        emit(r_type(7'h00, 5'd7, 5'd5, 3'b001, 5'd18));
        emit(r_type(7'h00, 5'd7, 5'd5, 3'b101, 5'd19)); // srl
        emit(r_type(7'h20, 5'd7, 5'd5, 3'b101, 5'd20)); // sra
        emit(i_type(imm, 5'd5, 3'b000, 5'd21, op_imm));
        emit(r_type(7'h00, 5'd0, 5'd11, 3'b000, 5'd10));
        // Fold as a0 = (a0 << 1) ^ xk
        for (int k = 12; k <= 21; k++) begin
            emit(i_type(12'd1, 5'd10, 3'b001, 5'd10, op_imm));
            emit(r_type(7'h00, 5'(k), 5'd10, 3'b100, 5'd10));
        end
        emit(ebreak_inst);
        run_program("arith");
        res[0]  = a + b;
        res[1]  = a - b;
        res[2]  = a ^ b;
        res[3]  = a | b;
        res[4]  = a & b;
        res[5]  = {31'd0, $signed(a) < $signed(b)};
        res[6]  = {31'd0, a < b};
        res[7]  = a << sh;
        res[8]  = a >> sh;
        res[9]  = 32'($signed(a) >>> sh);
        res[10] = a + {{20{imm[11]}}, imm};
        acc = res[0];
        for (int k = 1; k < 11; k++) begin
            acc = (acc << 1) ^ res[k];
        end
        check_word("arith a0", acc, a0);
        report_test("arith", fails_before);
    endtask

    task automatic load_store_sum();
        logic [31:0] w;
        logic [15:0] h;
        logic [7:0]  b;
        logic [31:0] expected;
        int          fails_before;
        fails_before = checks_failed;
        w = $urandom() | 32'h8000_0000; // Top byte and top half negative
        h = 16'($urandom()) | 16'h8000;
        b = 8'($urandom()) | 8'h80;
        new_program();
        emit(i_type(12'h100, 5'd0, 3'b000, 5'd5, op_imm));
        load_const(5'd6, w);
        load_const(5'd7, {16'd0, h});
        emit(i_type({4'd0, b}, 5'd0, 3'b000, 5'd8, op_imm));
        emit(s_type(12'd0, 5'd6, 5'd5, 3'b010)); // sw
        emit(s_type(12'd6, 5'd7, 5'd5, 3'b001)); // sh
        emit(s_type(12'd9, 5'd8, 5'd5, 3'b000)); // sb
        emit(i_type(12'd0, 5'd5, 3'b010, 5'd11, op_load));
        emit(i_type(12'd6, 5'd5, 3'b001, 5'd12, op_load));
        emit(i_type(12'd6, 5'd5, 3'b101, 5'd13, op_load)); // lhu
        emit(i_type(12'd9, 5'd5, 3'b000, 5'd14, op_load));
        emit(i_type(12'd9, 5'd5, 3'b100, 5'd15, op_load)); // lbu
        emit(i_type(12'd3, 5'd5, 3'b000, 5'd16, op_load));
        emit(i_type(12'd2, 5'd5, 3'b101, 5'd17, op_load));
        for (int k = 11; k <= 17; k++) begin
            emit(r_type(7'h00, 5'(k), 5'd10, 3'b000, 5'd10));
        end
        emit(ebreak_inst);
        run_program("memory");
        expected = w + {{16{h[15]}}, h} + {16'd0, h} + {{24{b[7]}}, b} + {24'd0, b}
                 + {{24{w[31]}}, w[31:24]} + {16'd0, w[31:16]};
        check_word("memory a0", expected, a0);
        report_test("memory", fails_before);
    endtask

    task automatic branch_loop();
        logic [2:0]  kind [5];
        logic [4:0]  take_lhs [5];
        logic [4:0]  take_rhs [5];
        logic [4:0]  skip_lhs [5];
        logic [4:0]  skip_rhs [5];
        int          n;
        int          fails_before;
        fails_before = checks_failed;
        n = 1 + int'($urandom() % 20);
        // x7 holds -1 and x8 holds 1 for BEQ, BLT, BGE, BLTU and BGEU
        kind     = '{3'b000, 3'b100, 3'b101, 3'b110, 3'b111};
        take_lhs = '{5'd8, 5'd7, 5'd8, 5'd8, 5'd7};
        take_rhs = '{5'd8, 5'd8, 5'd7, 5'd7, 5'd8};
        skip_lhs = '{5'd7, 5'd8, 5'd7, 5'd7, 5'd8};
        skip_rhs = '{5'd8, 5'd7, 5'd8, 5'd8, 5'd7};
        new_program();
        emit(i_type(12'(n), 5'd0, 3'b000, 5'd5, op_imm));
        emit(i_type(12'hfff, 5'd0, 3'b000, 5'd7, op_imm));
        emit(i_type(12'd1, 5'd0, 3'b000, 5'd8, op_imm));
        emit(r_type(7'h00, 5'd5, 5'd10, 3'b000, 5'd10)); // Loop body
        emit(i_type(12'hfff, 5'd5, 3'b000, 5'd5, op_imm));
        emit(b_type(13'h1ff8, 5'd0, 5'd5, 3'b001)); // bne back by 8
        for (int k = 0; k < 5; k++) begin
            emit(b_type(13'd8, take_rhs[k], take_lhs[k], kind[k]));
            emit(i_type(12'(32'd1 << k), 5'd6, 3'b110, 5'd6, op_imm)); // Must be skipped
            emit(b_type(13'd8, skip_rhs[k], skip_lhs[k], kind[k]));
            emit(i_type(12'(32'd1 << (k + 5)), 5'd6, 3'b110, 5'd6, op_imm));
        end
        emit(r_type(7'h00, 5'd6, 5'd10, 3'b000, 5'd10));
        emit(ebreak_inst);
        run_program("branch");
        check_word("branch a0", 32'(n * (n + 1) / 2) + 32'h3e0, a0);
        report_test("branch", fails_before);
    endtask

    task automatic jump_link();
        logic [31:0] expected;
        int          fails_before;
        fails_before = checks_failed;
        new_program();
        emit(j_type(21'd12, 5'd1));                                // Call index 3
        emit(i_type(12'h100, 5'd10, 3'b000, 5'd10, op_imm));       // Return lands here
        emit(j_type(21'd12, 5'd0));                                // On to index 5
        emit(i_type(12'd7, 5'd10, 3'b000, 5'd10, op_imm));
        emit(i_type(12'd0, 5'd1, 3'b000, 5'd0, op_jalr));          // Return
        emit(u_type(20'h12345, 5'd11, op_lui));
        emit(u_type(20'h00001, 5'd12, op_auipc));                  // Index 6
        emit(r_type(7'h00, 5'd11, 5'd10, 3'b000, 5'd10));
        emit(r_type(7'h00, 5'd12, 5'd10, 3'b000, 5'd10));
        emit(r_type(7'h00, 5'd1, 5'd10, 3'b000, 5'd10));
        emit(ebreak_inst);                                         // Index 10
        run_program("jump");
        expected = 32'h107 + 32'h1234_5000 + (reset_pc + 32'd24 + 32'h1000)
                 + (reset_pc + 32'd4);
        check_word("jump a0", expected, a0);
        check_word("jump halt pc", reset_pc + 32'd40, pc);
        report_test("jump", fails_before);
    endtask

    task automatic halt_hold();
        int fails_before;
        fails_before = checks_failed;
        new_program();
        emit(i_type(12'd55, 5'd0, 3'b000, 5'd10, op_imm));
        emit(i_type(12'd123, 5'd0, 3'b000, 5'd0, op_imm));
        emit(u_type(20'habcde, 5'd0, op_lui));
        emit(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd10)); // Copy x0
        emit(i_type(12'd3, 5'd10, 3'b000, 5'd10, op_imm));
        emit(ebreak_inst);
        emit(i_type(12'd99, 5'd10, 3'b000, 5'd10, op_imm));
        emit(i_type(12'd1, 5'd10, 3'b000, 5'd10, op_imm));
        run_program("halt");
        check_flag("halt halted", 1'b1, halted);
        check_word("halt pc", reset_pc + 32'd20, pc);
        repeat (10) begin
            @(posedge clk);
            #2;
            check_word("halt pc held", reset_pc + 32'd20, pc);
            check_flag("halt halted held", 1'b1, halted);
        end
        check_word("halt a0", 32'd3, a0);
        report_test("halt", fails_before);
    endtask

    initial begin
        void'($urandom(32'h68cb5042));
        rst_n         = 1'b0;
        inst          = ebreak_inst;
        cycles        = 0;
        checks_passed = 0;
        checks_failed = 0;
        arith_chain();
        load_store_sum();
        branch_loop();
        jump_link();
        halt_hold();
        $display("checks passed %0d, failed %0d", checks_passed, checks_failed);
        if (checks_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
rv_pkg.sv
inst_decoder.sv
reg_file.sv
alu.sv
data_mem.sv
rv_core.sv
tb_rv_core.sv

//--- Makefile
TOP := tb_rv_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir
